//--- hw/useq_params.svh
`ifndef USEQ_PARAMS_SVH
`define USEQ_PARAMS_SVH

// Data path and address width
`define USEQ_DW 8

// Program memory bytes, one per address
`define USEQ_MEM_DEPTH 256

// Register file size, last one is the link register
`define USEQ_NREGS 16

// Port event buffer entries
`define USEQ_FIFO_DEPTH 4

// Clocks per serialized bit
`define USEQ_BIT_CYCLES 4

`endif

//--- hw/useq_pkg.sv
`include "useq_params.svh"

package useq_pkg;

	// Top nibble of the instruction
	typedef enum logic [3:0] {
		LD, ST, SETB, ADD,
		SUB, EOR, AND, OR,
		JMPR, JNZ, ALU, LDIB,
		LDIT, IO, JSR, SBIT
	} op_group_e;

	typedef enum logic [3:0] {
		INC, DEC, ASL, LSR,
		ASR, SWAP, ROL, ROR,
		SWAPR0, SWAPR1, LDA, SIGT,
		SIEQ, SILT, NOT, CLR
	} alu_op_e;

	typedef enum logic [3:0] {
		OUT, OUTBIT, TGLBIT, IN,
		INBIT, JMP, CALL, RET,
		SEI, RTI, WAIT0, WAIT1,
		MASK4, ABS, NEG, WAITA
	} io_op_e;

	typedef enum logic [1:0] {
		FETCH, EXECUTE, LOADA
	} core_state_e;

	typedef struct packed {
		logic [`USEQ_DW-1:0] pc;    // Sent first
		logic [`USEQ_DW-1:0] value;
	} port_event_t;

endpackage

//--- hw/useq_prog_mem.sv
`timescale 1ns/1ns
`include "useq_params.svh"

module useq_prog_mem (
	input  logic                clk,
	input  logic                i_wr_en,
	input  logic [`USEQ_DW-1:0] i_wr_addr,
	input  logic [`USEQ_DW-1:0] i_wr_data,
	input  logic [`USEQ_DW-1:0] i_rd_addr,
	output logic [`USEQ_DW-1:0] o_rd_data
);

	logic [`USEQ_DW-1:0] mem [`USEQ_MEM_DEPTH];

	// Loader port
	always_ff @(posedge clk)
	begin
		if (i_wr_en)
			mem[i_wr_addr] <= i_wr_data;
	end

	// Same-cycle read for fetch and LDA
	assign o_rd_data = mem[i_rd_addr];

endmodule

//--- hw/useq_core.sv
`timescale 1ns/1ns
`include "useq_params.svh"

module useq_core (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  i_run,
	input  logic [`USEQ_DW-1:0]   i_mem_data,
	input  logic [`USEQ_DW-1:0]   i_port,
	input  logic                  i_evt_full,
	output logic [`USEQ_DW-1:0]   o_mem_addr,
	output logic [`USEQ_DW-1:0]   o_port,
	output logic                  o_evt_wr,
	output useq_pkg::port_event_t o_evt
);
	import useq_pkg::*;

	localparam int DW = `USEQ_DW;
	localparam int LINK = `USEQ_NREGS - 1;

	logic [DW-1:0] acc;
	logic [DW-1:0] pc;
	logic [DW-1:0] instr;
	logic [DW-1:0] regs [`USEQ_NREGS];
	logic [DW-1:0] l_i_port;
	core_state_e   state;

	op_group_e     grp;
	alu_op_e       alu_op;
	io_op_e        io_op;
	logic [3:0]    d_imm;
	logic [2:0]    s_imm;
	logic          b_imm;
	logic [DW-1:0] pc_inc;
	logic [DW-1:0] port_next;
	logic          port_wr;
	logic          stall;

	assign grp    = op_group_e'(instr[7:4]);
	assign alu_op = alu_op_e'(instr[3:0]);
	assign io_op  = io_op_e'(instr[3:0]);
	assign d_imm  = instr[3:0];
	assign s_imm  = instr[3:1];
	assign b_imm  = instr[0];
	assign pc_inc = pc + 1'b1;

	// LDA reads data through the fetch port
	assign o_mem_addr = (state == LOADA) ? acc : pc;

	// New port value of OUT, OUTBIT and TGLBIT
	always_comb
	begin
		port_next = o_port;
		port_wr = 1'b0;
		if (state == EXECUTE && grp == IO)
		begin
			case (io_op)
				OUT:
				begin
					port_next = acc;
					port_wr = 1'b1;
				end
				OUTBIT:
				begin
					port_next[regs[0][2:0]] = acc[0];
					port_wr = 1'b1;
				end
				TGLBIT:
				begin
					port_next[regs[1][2:0]] = ~o_port[regs[1][2:0]];
					port_wr = 1'b1;
				end
				default:
					port_wr = 1'b0;
			endcase
		end
	end

	assign stall     = port_wr && i_evt_full; // Hold in EXECUTE until buffer has room
	assign o_evt_wr  = i_run && port_wr && !i_evt_full;
	assign o_evt.pc    = pc;
	assign o_evt.value = port_next;

	always_ff @(posedge clk)
		l_i_port <= i_port;

	always_ff @(posedge clk)
	begin
		if (!rst_n || !i_run)
		begin
			acc <= '0;
			pc <= '0;
			state <= FETCH;
			o_port <= '0;
			for (int i = 0; i < `USEQ_NREGS; i++)
				regs[i] <= '0;
		end
		else
		begin
			case (state)
				FETCH:
				begin
					instr <= i_mem_data;
					state <= EXECUTE;
				end
				EXECUTE:
				begin
					if (!stall)
					begin
						pc <= pc_inc; // Default, overridden by jumps and skips
						state <= FETCH;
						case (grp)
							LD:   acc <= regs[d_imm];
							ST:   regs[d_imm] <= acc;
							SETB: acc[s_imm] <= b_imm;
							ADD:  acc <= acc + regs[d_imm];
							SUB:  acc <= acc - regs[d_imm];
							EOR:  acc <= acc ^ regs[d_imm];
							AND:  acc <= acc & regs[d_imm];
							OR:   acc <= acc | regs[d_imm];
							JMPR: pc <= pc_inc + DW'(d_imm);
							JNZ:
							begin
								if (acc != '0)
									pc <= pc - DW'(d_imm) - 1'b1;
							end
							ALU:
							begin
								case (alu_op)
									INC:  acc <= acc + 1'b1;
									DEC:  acc <= acc - 1'b1;
									ASL:  acc <= acc << 1;
									LSR:  acc <= acc >> 1;
									ASR:  acc <= {acc[DW-1], acc[DW-1:1]};
									SWAP: acc <= {acc[3:0], acc[7:4]};
									ROL:  acc <= {acc[DW-2:0], acc[DW-1]};
									ROR:  acc <= {acc[0], acc[DW-1:1]};
									SWAPR0:
									begin
										acc <= regs[0];
										regs[0] <= acc;
									end
									SWAPR1:
									begin
										acc <= regs[1];
										regs[1] <= acc;
									end
									LDA:
									begin
										pc <= pc; // Advances after the data read
										state <= LOADA;
									end
									SIGT:
									begin
										if (acc > regs[0])
											pc <= pc_inc + 1'b1;
									end
									SIEQ:
									begin
										if (acc == regs[0])
											pc <= pc_inc + 1'b1;
									end
									SILT:
									begin
										if (acc < regs[0])
											pc <= pc_inc + 1'b1;
									end
									NOT:  acc <= ~acc;
									CLR:  acc <= '0;
								endcase
							end
							LDIB: acc[3:0] <= d_imm;
							LDIT: acc[7:4] <= d_imm;
							IO:
							begin
								case (io_op)
									OUT, OUTBIT, TGLBIT:
										o_port <= port_next;
									IN:    acc <= l_i_port;
									INBIT: acc <= DW'(l_i_port[regs[0][2:0]]);
									JMP:   pc <= acc;
									CALL:
									begin
										regs[LINK] <= pc_inc; // Return address
										pc <= acc;
									end
									RET:   pc <= regs[LINK];
									MASK4: acc <= acc & DW'(4'hf);
									ABS:   acc <= acc[DW-1] ? (~acc + 1'b1) : acc;
									NEG:   acc <= ~acc + 1'b1;
									// SEI, RTI and the waits only step PC
									default:
										pc <= pc_inc;
								endcase
							end
							JSR:  pc <= {d_imm, 4'b0};
							SBIT:
							begin
								if (acc[s_imm] == b_imm)
									pc <= pc_inc + 1'b1;
							end
						endcase
					end
				end
				LOADA:
				begin
					acc <= i_mem_data;
					pc <= pc_inc;
					state <= FETCH;
				end
				default:
					state <= FETCH;
			endcase
		end
	end

endmodule

//--- hw/useq_event_fifo.sv
`timescale 1ns/1ns
`include "useq_params.svh"

module useq_event_fifo (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  i_wr,
	input  useq_pkg::port_event_t i_evt,
	input  logic                  i_rd,
	output useq_pkg::port_event_t o_evt,
	output logic                  o_full,
	output logic                  o_empty
);
	import useq_pkg::*;

	localparam int DEPTH = `USEQ_FIFO_DEPTH;
	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	port_event_t   mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;

	always_ff @(posedge clk)
	begin
		if (i_wr)
			mem[wr_ptr] <= i_evt;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (i_wr)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (i_rd)
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({i_wr, i_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // Both or neither
			endcase
		end
	end

	assign o_evt   = mem[rd_ptr];
	assign o_full  = (count == (AW+1)'(DEPTH));
	assign o_empty = (count == '0);

endmodule

//--- hw/useq_port_serializer.sv
`timescale 1ns/1ns
`include "useq_params.svh"

module useq_port_serializer (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  i_empty,
	input  useq_pkg::port_event_t i_evt,
	output logic                  o_rd,
	output logic                  o_ser_bit,
	output logic                  o_ser_strobe,
	output logic                  o_ser_last
);
	import useq_pkg::*;

	localparam int EW = $bits(port_event_t);
	localparam int BC = `USEQ_BIT_CYCLES;
	localparam int CW = (BC > 1) ? $clog2(BC) : 1;
	localparam int NW = $clog2(EW);

	logic [EW-1:0] shreg;
	logic [CW-1:0] cyc_cnt;
	logic [NW-1:0] bit_cnt;
	logic          busy;

	assign o_rd         = !busy && !i_empty;
	assign o_ser_bit    = shreg[EW-1]; // MSB first
	assign o_ser_strobe = busy && (cyc_cnt == CW'(BC - 1));
	assign o_ser_last   = o_ser_strobe && (bit_cnt == NW'(EW - 1));

	always_ff @(posedge clk)
	begin
		if (o_rd)
			shreg <= i_evt;
		else if (o_ser_strobe)
			shreg <= shreg << 1;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			busy <= 1'b0;
			cyc_cnt <= '0;
			bit_cnt <= '0;
		end
		else if (o_rd)
		begin
			busy <= 1'b1;
			cyc_cnt <= '0;
			bit_cnt <= '0;
		end
		else if (busy)
		begin
			if (o_ser_strobe)
			begin
				cyc_cnt <= '0;
				bit_cnt <= bit_cnt + 1'b1;
				if (o_ser_last)
					busy <= 1'b0;
			end
			else
				cyc_cnt <= cyc_cnt + 1'b1;
		end
	end

endmodule

//--- hw/useq_top.sv
`timescale 1ns/1ns
`include "useq_params.svh"

module useq_top (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                i_run,
	input  logic                i_load_en,
	input  logic [`USEQ_DW-1:0] i_load_addr,
	input  logic [`USEQ_DW-1:0] i_load_data,
	input  logic [`USEQ_DW-1:0] i_port,
	output logic [`USEQ_DW-1:0] o_port,
	output logic                o_ser_bit,
	output logic                o_ser_strobe,
	output logic                o_ser_last
);
	import useq_pkg::*;

	logic [`USEQ_DW-1:0] mem_addr;
	logic [`USEQ_DW-1:0] mem_data;
	logic                evt_wr;
	logic                evt_rd;
	logic                evt_full;
	logic                evt_empty;
	port_event_t         core_evt;
	port_event_t         fifo_evt;

	useq_prog_mem i_useq_prog_mem (
		.clk       (clk),
		.i_wr_en   (i_load_en),
		.i_wr_addr (i_load_addr),
		.i_wr_data (i_load_data),
		.i_rd_addr (mem_addr),
		.o_rd_data (mem_data)
	);

	useq_core i_useq_core (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_run      (i_run),
		.i_mem_data (mem_data),
		.i_port     (i_port),
		.i_evt_full (evt_full),
		.o_mem_addr (mem_addr),
		.o_port     (o_port),
		.o_evt_wr   (evt_wr),
		.o_evt      (core_evt)
	);

	useq_event_fifo i_useq_event_fifo (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_wr    (evt_wr),
		.i_evt   (core_evt),
		.i_rd    (evt_rd),
		.o_evt   (fifo_evt),
		.o_full  (evt_full),
		.o_empty (evt_empty)
	);

	useq_port_serializer i_useq_port_serializer (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_empty      (evt_empty),
		.i_evt        (fifo_evt),
		.o_rd         (evt_rd),
		.o_ser_bit    (o_ser_bit),
		.o_ser_strobe (o_ser_strobe),
		.o_ser_last   (o_ser_last)
	);

endmodule

//--- tests/useq_asserts.sv
`timescale 1ns/1ns

module useq_asserts (
	input logic clk,
	input logic rst_n,
	input logic i_evt_wr,
	input logic i_evt_full,
	input logic i_evt_rd,
	input logic i_evt_empty,
	input logic i_ser_strobe
);

	int n_fail = 0;

	a_wr_full: assert property (@(posedge clk) disable iff (!rst_n)
		!(i_evt_wr && i_evt_full))
	else
	begin
		$error("event written while FIFO full");
		n_fail++;
	end

	a_rd_empty: assert property (@(posedge clk) disable iff (!rst_n)
		!(i_evt_rd && i_evt_empty))
	else
	begin
		$error("event popped while FIFO empty");
		n_fail++;
	end

	// One bit per period at most
	a_strobe_gap: assert property (@(posedge clk) disable iff (!rst_n)
		i_ser_strobe |=> !i_ser_strobe)
	else
	begin
		$error("serializer strobe high on two cycles in a row");
		n_fail++;
	end

endmodule

bind useq_top useq_asserts i_useq_asserts (
	.clk          (clk),
	.rst_n        (rst_n),
	.i_evt_wr     (evt_wr),
	.i_evt_full   (evt_full),
	.i_evt_rd     (evt_rd),
	.i_evt_empty  (evt_empty),
	.i_ser_strobe (o_ser_strobe)
);

//--- tests/useq_ref_model.svh
`ifndef USEQ_REF_MODEL_SVH
`define USEQ_REF_MODEL_SVH

localparam int MODEL_STEPS = 3000;
localparam int MODEL_EVENTS = 64;

logic [7:0]  m_mem [256]; // Program image, also loaded into the DUT
logic [7:0]  m_regs [16];
logic [7:0]  m_acc;
logic [7:0]  m_pc;
logic [7:0]  m_port;
logic [15:0] exp_evt [$]; // {pc, value}

task automatic alu_step(input logic [3:0] sub, inout logic [7:0] nxt);
	logic [7:0] a;
	a = m_acc;
	case (sub)
		4'h0: m_acc = a + 8'd1;
		4'h1: m_acc = a - 8'd1;
		4'h2: m_acc = {a[6:0], 1'b0};
		4'h3: m_acc = {1'b0, a[7:1]};
		4'h4: m_acc = {a[7], a[7:1]};
		4'h5: m_acc = {a[3:0], a[7:4]};
		4'h6: m_acc = {a[6:0], a[7]};
		4'h7: m_acc = {a[0], a[7:1]};
		4'h8:
		begin
			m_acc = m_regs[0];
			m_regs[0] = a;
		end
		4'h9:
		begin
			m_acc = m_regs[1];
			m_regs[1] = a;
		end
		4'ha: m_acc = m_mem[a];
		4'hb:
		begin
			if (a > m_regs[0])
				nxt = nxt + 8'd1;
		end
		4'hc:
		begin
			if (a == m_regs[0])
				nxt = nxt + 8'd1;
		end
		4'hd:
		begin
			if (a < m_regs[0])
				nxt = nxt + 8'd1;
		end
		4'he: m_acc = ~a;
		default: m_acc = 8'h00;
	endcase
endtask

task automatic io_step(input logic [3:0] sub, input logic [7:0] in_port,
		inout logic [7:0] nxt);
	logic [7:0] p;
	p = m_port;
	case (sub)
		4'h0: p = m_acc;
		4'h1: p[m_regs[0][2:0]] = m_acc[0];
		4'h2: p[m_regs[1][2:0]] = ~p[m_regs[1][2:0]];
		4'h3: m_acc = in_port;
		4'h4: m_acc = {7'h00, in_port[m_regs[0][2:0]]};
		4'h5: nxt = m_acc;
		4'h6:
		begin
			m_regs[15] = nxt; // Link
			nxt = m_acc;
		end
		4'h7: nxt = m_regs[15];
		4'hc: m_acc = {4'h0, m_acc[3:0]};
		4'hd:
		begin
			if (m_acc[7])
				m_acc = 8'h00 - m_acc;
		end
		4'he: m_acc = 8'h00 - m_acc;
		default: p = m_port; // SEI, RTI, waits
	endcase
	if (sub <= 4'h2)
	begin
		m_port = p;
		exp_evt.push_back({m_pc, p});
	end
endtask

task automatic model_step(input logic [7:0] in_port);
	logic [7:0] ins;
	logic [3:0] lo;
	logic [7:0] r;
	logic [7:0] nxt;
	ins = m_mem[m_pc];
	lo = ins[3:0];
	r = m_regs[lo];
	nxt = m_pc + 8'd1;
	case (ins[7:4])
		4'h0: m_acc = r;
		4'h1: m_regs[lo] = m_acc;
		4'h2: m_acc[lo[3:1]] = lo[0];
		4'h3: m_acc = m_acc + r;
		4'h4: m_acc = m_acc - r;
		4'h5: m_acc = m_acc ^ r;
		4'h6: m_acc = m_acc & r;
		4'h7: m_acc = m_acc | r;
		4'h8: nxt = nxt + {4'h0, lo};
		4'h9:
		begin
			if (m_acc != 8'h00)
				nxt = m_pc - {4'h0, lo} - 8'd1;
		end
		4'ha: alu_step(lo, nxt);
		4'hb: m_acc[3:0] = lo;
		4'hc: m_acc[7:4] = lo;
		4'hd: io_step(lo, in_port, nxt);
		4'he: nxt = {lo, 4'h0};
		default:
		begin
			if (m_acc[lo[3:1]] == lo[0])
				nxt = nxt + 8'd1;
		end
	endcase
	m_pc = nxt;
endtask

// Runs from reset state, fills exp_evt
task automatic run_model(input logic [7:0] in_port);
	int steps;
	m_acc = 8'h00;
	m_pc = 8'h00;
	m_port = 8'h00;
	for (int i = 0; i < 16; i++)
		m_regs[4'(i)] = 8'h00;
	exp_evt.delete();
	steps = 0;
	while (steps < MODEL_STEPS && exp_evt.size() < MODEL_EVENTS)
	begin
		model_step(in_port);
		steps++;
	end
endtask

`endif

//--- tests/useq_tb.sv
`timescale 1ns/1ns
`include "useq_params.svh"

module useq_tb;
	import useq_pkg::*;

	localparam int RUN_CYCLES = 3000;
	localparam int DRAIN_CYCLES = (`USEQ_FIFO_DEPTH + 2) * 16 * `USEQ_BIT_CYCLES;
	localparam int NUM_RUNS = 24;
	localparam int RUN_LEN = RUN_CYCLES + 256 + DRAIN_CYCLES + 16;
	localparam int MAX_CYCLES = NUM_RUNS * RUN_LEN + 1000;

	logic        clk;
	logic        rst_n;
	logic        i_run;
	logic        i_load_en;
	logic [7:0]  i_load_addr;
	logic [7:0]  i_load_data;
	logic [7:0]  i_port;
	logic [7:0]  o_port;
	logic        o_ser_bit;
	logic        o_ser_strobe;
	logic        o_ser_last;

	int          errors;
	int          checks;
	int          cycles = 0;
	int          got_base;
	logic [7:0]  wp;
	logic [15:0] shift_word;
	logic [15:0] got_evt [$];

	`include "useq_ref_model.svh"

	useq_top i_useq_top (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_run        (i_run),
		.i_load_en    (i_load_en),
		.i_load_addr  (i_load_addr),
		.i_load_data  (i_load_data),
		.i_port       (i_port),
		.o_port       (o_port),
		.o_ser_bit    (o_ser_bit),
		.o_ser_strobe (o_ser_strobe),
		.o_ser_last   (o_ser_last)
	);

	always #20 clk = ~clk;

	// Rebuild events from the bit stream
	always @(posedge clk)
	begin
		if (o_ser_strobe === 1'b1)
		begin
			shift_word <= {shift_word[14:0], o_ser_bit};
			if (o_ser_last === 1'b1)
				got_evt.push_back({shift_word[14:0], o_ser_bit});
		end
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES)
		begin
			$display("Error: timeout, the run did not finish within %0d cycles", MAX_CYCLES);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic compare(input string name, input logic [15:0] exp, input logic [15:0] act);
		checks++;
		if (exp !== act)
		begin
			errors++;
			$display("Fail %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic fill_image();
		for (int a = 0; a < 256; a++)
			m_mem[8'(a)] = 8'(a * 77) ^ 8'h96;
		m_mem[8'hf0] = {JSR, 4'hf}; // Halt by jumping to itself
		wp = 8'h00;
	endtask

	task automatic emit(input logic [7:0] ins);
		m_mem[wp] = ins;
		wp = wp + 8'd1;
	endtask

	task automatic emit_out(input logic [7:0] ins);
		emit(ins);
		emit({IO, OUT});
	endtask

	task automatic check_events(input string name, input logic [7:0] port_seen,
			input logic full_check);
		int n_got;
		n_got = got_evt.size() - got_base;
		if (full_check)
		begin
			compare({name, " event count"}, 16'(exp_evt.size()), 16'(n_got));
			compare({name, " final port"}, {8'h00, m_port}, {8'h00, port_seen});
		end
		else
		begin
			compare({name, " any events"}, 16'(exp_evt.size() > 0), 16'(n_got > 0));
			compare({name, " no extra events"}, 16'h0001, 16'(n_got <= exp_evt.size()));
		end
		for (int i = 0; i < n_got && i < exp_evt.size(); i++)
			compare($sformatf("%s event %0d", name, i), exp_evt[i], got_evt[got_base + i]);
	endtask

	task automatic run_program(input string name, input logic [7:0] in_port,
			input logic full_check);
		logic [7:0] port_seen;
		for (int a = 0; a < 256; a++)
		begin
			@(posedge clk);
			compare("stopped port", 16'h0000, {8'h00, o_port});
			compare("stopped strobe", 16'h0000, {15'h0000, o_ser_strobe});
			i_load_en <= 1'b1;
			i_load_addr <= 8'(a);
			i_load_data <= m_mem[8'(a)];
		end
		@(posedge clk);
		i_load_en <= 1'b0;
		i_port <= in_port;
		i_run <= 1'b1;
		got_base = got_evt.size();
		repeat (RUN_CYCLES) @(posedge clk);
		port_seen = o_port;
		i_run <= 1'b0;
		repeat (DRAIN_CYCLES) @(posedge clk); // FIFO and serializer empty out
		run_model(in_port);
		check_events(name, port_seen, full_check);
	endtask

	task automatic build_alu_prog();
		fill_image();
		emit({LDIB, 4'h5});
		emit_out({LDIT, 4'ha});
		emit_out({ALU, INC});
		emit({ALU, DEC});
		emit_out({ALU, DEC});
		emit_out({ALU, ASL});
		emit_out({ALU, LSR});
		emit_out({ALU, ASR});
		emit_out({ALU, SWAP});
		emit_out({ALU, ROL});
		emit_out({ALU, ROR});
		emit_out({SETB, 3'd2, 1'b1});
		emit_out({SETB, 3'd7, 1'b0});
		emit_out({ALU, NOT});
		emit_out({IO, NEG});
		emit_out({IO, ABS});
		emit_out({LDIT, 4'h9});
		emit_out({IO, ABS}); // Negative input
		emit_out({IO, MASK4});
		emit_out({ALU, CLR});
		emit({JSR, 4'hf});
	endtask

	task automatic build_reg_prog();
		fill_image();
		emit({LDIB, 4'h3});
		emit({ST, 4'h2});
		emit({LDIB, 4'h9});
		emit({ST, 4'h0});
		emit({LDIT, 4'h4});
		emit_out({ADD, 4'h2});
		emit_out({SUB, 4'h0});
		emit_out({EOR, 4'h2});
		emit({AND, 4'h0});
		emit_out({OR, 4'h2});
		emit_out({ALU, SWAPR0});
		emit_out({ALU, SWAPR1});
		emit_out({LD, 4'h1});
		emit({LDIB, 4'h0});
		emit({LDIT, 4'hc});
		emit_out({ALU, LDA}); // Data byte at C0
		emit({JMPR, 4'h1});
		emit({LDIB, 4'hf});
		emit({LDIB, 4'h3});
		emit({LDIT, 4'h0});
		emit_out({ALU, DEC}); // Count down to zero
		emit({JNZ, 4'h1});
		emit({JSR, 4'h8});
		wp = 8'h80;
		emit({LDIB, 4'h0});
		emit({LDIT, 4'ha});
		emit({IO, CALL});
		emit_out({LDIB, 4'h5});
		emit({ST, 4'h0});
		emit({ALU, SIEQ});
		emit({IO, OUT});
		emit({ALU, INC});
		emit({ALU, SIGT});
		emit({IO, OUT});
		emit({ALU, SILT});
		emit({IO, OUT});
		emit({SBIT, 3'd1, 1'b1});
		emit({IO, OUT});
		emit({SBIT, 3'd0, 1'b1});
		emit({IO, OUT});
		emit({JSR, 4'hf});
		wp = 8'ha0;
		emit_out({ALU, INC}); // Subroutine
		emit({IO, RET});
	endtask

	task automatic build_bit_prog();
		fill_image();
		emit({LDIB, 4'h3});
		emit({ST, 4'h0});
		emit({LDIB, 4'h1});
		emit({IO, OUTBIT});
		emit({LDIB, 4'h6});
		emit({ST, 4'h1});
		emit({IO, TGLBIT});
		emit({IO, TGLBIT});
		emit({LDIB, 4'h0});
		emit({ST, 4'h1});
		emit({IO, TGLBIT});
		emit_out({IO, IN});
		emit({LDIB, 4'h5});
		emit({ST, 4'h0});
		emit_out({IO, INBIT});
		emit({IO, OUTBIT});
		emit({LDIB, 4'h7});
		emit({ST, 4'h0});
		emit({IO, INBIT});
		emit({IO, OUTBIT});
		emit({JSR, 4'hf});
	endtask

	initial
	begin
		clk = 1'b0;
		rst_n = 1'b0;
		i_run = 1'b0;
		i_load_en = 1'b0;
		i_load_addr = 8'h00;
		i_load_data = 8'h00;
		i_port = 8'h00;
		errors = 0;
		checks = 0;
		void'($urandom(32'hba3557fd));
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;

		build_alu_prog();
		run_program("alu", 8'h00, 1'b1);
		build_reg_prog();
		run_program("regs", 8'h00, 1'b1);
		build_bit_prog();
		run_program("port bits", 8'($urandom), 1'b1);

		for (int r = 0; r < 20; r++)
		begin
			for (int a = 0; a < 256; a++)
				m_mem[8'(a)] = 8'($urandom);
			run_program($sformatf("random %0d", r), 8'($urandom), 1'b0);
		end

		// Twenty OUTs from EC up to 00, much faster than the serializer
		fill_image();
		emit({LDIB, 4'hc});
		emit({LDIT, 4'he});
		emit({ALU, INC});
		emit({IO, OUT});
		emit({JNZ, 4'h1});
		emit({JSR, 4'hf});
		run_program("back-pressure", 8'h00, 1'b1);

		$display("Checks %0d, mismatches %0d, assertion failures %0d",
			checks, errors, i_useq_top.i_useq_asserts.n_fail);
		if (errors == 0 && i_useq_top.i_useq_asserts.n_fail == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- useq_sub.f
+incdir+hw
+incdir+tests
hw/useq_pkg.sv
hw/useq_prog_mem.sv
hw/useq_core.sv
hw/useq_event_fifo.sv
hw/useq_port_serializer.sv
hw/useq_top.sv
tests/useq_asserts.sv
tests/useq_tb.sv

//--- Makefile
SIM = obj_dir/useq_tb

all: run

run:
	verilator --binary --timing --assert -f useq_sub.f --top-module useq_tb -o useq_tb
	./$(SIM) +verilator+error+limit+100 | tee /dev/stderr | grep -qx "TEST PASSED"

lint:
	verilator --lint-only --timing --assert -f useq_sub.f --top-module useq_tb

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
